/* flist.f */
hw/uart_pkg.sv
hw/uart_reg_if.sv
hw/uart_register.sv
hw/uart_baudgen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_interrupts.sv
hw/uart.sv
verif/uart_checker.sv
verif/uart_tb.sv

/* hw/uart.sv */
module uart (
  input  logic       clk_i,
  input  logic       reset_i,
  // Bus, OBI style req/gnt/rvalid
  input  logic       req_i,
  input  logic       we_i,
  input  logic [2:0] addr_i,
  input  logic [7:0] wdata_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output logic [7:0] rdata_o,
  // Serial lines
  input  logic       rxd_i,
  output logic       txd_o,
  output logic       irq_o
);

  logic baud_tick;  // 16x oversample
  logic txd;        // Transmitter output before loopback
  logic rxd;        // Receiver input after loopback
  logic loopback;

  uart_reg_if reg_if ();

  ////////////////////////////////////////////////////////////
  // Registers and baud rate
  ////////////////////////////////////////////////////////////

  uart_register i_uart_register (
    .clk_i,
    .reset_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .loopback_o (loopback),
    .regs_if    (reg_if.regs)
  );

  uart_baudgen i_uart_baudgen (
    .clk_i,
    .reset_i,
    .divisor_i (reg_if.divisor),
    .tick_o    (baud_tick)
  );

  // Loopback, TX turned back into RX, pin held idle
  assign txd_o = loopback ? 1'b1 : txd;
  assign rxd   = loopback ? txd  : rxd_i;

  ////////////////////////////////////////////////////////////
  // Serial blocks and interrupts
  ////////////////////////////////////////////////////////////

  uart_rx i_uart_rx (
    .clk_i,
    .reset_i,
    .tick_i (baud_tick),
    .rxd_i  (rxd),
    .rx_if  (reg_if.rx)
  );

  uart_tx i_uart_tx (
    .clk_i,
    .reset_i,
    .tick_i (baud_tick),
    .txd_o  (txd),
    .tx_if  (reg_if.tx)
  );

  uart_interrupts i_uart_interrupts (
    .clk_i,
    .reset_i,
    .irq_o,
    .irq_if (reg_if.irq)
  );

endmodule

/* hw/uart_baudgen.sv */
module uart_baudgen (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [15:0] divisor_i,
  output logic        tick_o
);

  logic [15:0] cnt;  // Counts down to zero, then reloads

  ////////////////////////////////////////////////////////////
  // 16x oversample tick
  ////////////////////////////////////////////////////////////

  // One pulse every divisor+1 clocks
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt    <= '0;
      tick_o <= 1'b0;
    end else if (divisor_i == '0) begin
      cnt    <= '0;     // Generator stopped
      tick_o <= 1'b0;
    end else if (cnt == '0) begin
      cnt    <= divisor_i;  // Reload
      tick_o <= 1'b1;
    end else begin
      cnt    <= cnt - 16'd1;
      tick_o <= 1'b0;
    end
  end

  // A new divisor is picked up at the next reload
  // Tick is registered, so RX and TX see a clean single-cycle pulse

endmodule

/* hw/uart_interrupts.sv */
module uart_interrupts (
  input  logic    clk_i,
  input  logic    reset_i,
  output logic    irq_o,
  uart_reg_if.irq irq_if
);
  import uart_pkg::*;

  logic       ls_pend;   // Line status error
  logic       rx_pend;   // Received data available
  logic       thr_pend;  // THR empty
  logic [3:0] id_next;

  // Causes masked by IER
  assign ls_pend  = irq_if.ier[2] & (irq_if.overrun | irq_if.par_err | irq_if.frame_err);
  assign rx_pend  = irq_if.ier[0] & irq_if.data_ready;
  assign thr_pend = irq_if.ier[1] & irq_if.thr_empty;

  // Highest priority first
  always_comb begin
    if (ls_pend) id_next = ISR_LINE_STATUS;
    else if (rx_pend) id_next = ISR_RX_DATA;
    else if (thr_pend) id_next = ISR_THR_EMPTY;
    else id_next = ISR_NONE;
  end

  // One cycle behind the flags
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_if.isr_id <= ISR_NONE;
      irq_o         <= 1'b0;
    end else begin
      irq_if.isr_id <= id_next;
      irq_o         <= (id_next != ISR_NONE);
    end
  end

endmodule

/* hw/uart_pkg.sv */
package uart_pkg;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam logic [2:0] ADDR_RHR_THR = 3'd0;  // RHR on read, THR on write, DLL with DLAB
  localparam logic [2:0] ADDR_IER     = 3'd1;  // DLM with DLAB
  localparam logic [2:0] ADDR_ISR     = 3'd2;  // Read only
  localparam logic [2:0] ADDR_LCR     = 3'd3;
  localparam logic [2:0] ADDR_MCR     = 3'd4;  // Only loopback kept
  localparam logic [2:0] ADDR_LSR     = 3'd5;
  localparam logic [2:0] ADDR_SCR     = 3'd7;

  ////////////////////////////////////////////////////////////
  // Interrupt identities
  ////////////////////////////////////////////////////////////

  localparam logic [3:0] ISR_NONE        = 4'h1;  // Bit 0 set means nothing pending
  localparam logic [3:0] ISR_THR_EMPTY   = 4'h2;  // Lowest priority
  localparam logic [3:0] ISR_RX_DATA     = 4'h4;
  localparam logic [3:0] ISR_LINE_STATUS = 4'h6;  // Highest priority

  // Baud ticks per serial bit
  localparam int OVERSAMPLE = 16;

  // Frame phases, shared by RX and TX sequencers
  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_START  = 3'd1;
  localparam logic [2:0] ST_DATA   = 3'd2;
  localparam logic [2:0] ST_PARITY = 3'd3;
  localparam logic [2:0] ST_STOP   = 3'd4;

  ////////////////////////////////////////////////////////////
  // Line control register
  ////////////////////////////////////////////////////////////

  // Whole byte on the bus, fields in the datapath
  typedef union packed {
    logic [7:0] arr;
    struct packed {
      logic       dlab;      // Divisor latch access
      logic [1:0] rsvd;      // Stick parity and break, not implemented
      logic       par_even;  // 1 even, 0 odd
      logic       par_en;
      logic       stop2;     // Two stop bits
      logic [1:0] word_len;  // 0..3 for 5..8 data bits
    } strct;
  } lcr_t;

endpackage

/* hw/uart_reg_if.sv */
interface uart_reg_if;
  import uart_pkg::*;

  // Config and strobes, from the register block
  lcr_t        lcr;
  logic [15:0] divisor;   // {DLM, DLL}
  logic [2:0]  ier;       // [2] line status, [1] THR empty, [0] RX data
  logic [7:0]  thr_data;
  logic        thr_wr;
  logic        rhr_rd;
  logic        lsr_rd;

  // Receiver status
  logic [7:0]  rx_data;
  logic        data_ready;
  logic        overrun;
  logic        par_err;
  logic        frame_err;

  // Transmitter status
  logic        thr_empty;
  logic        tx_empty;

  logic [3:0]  isr_id;    // Registered in the interrupt block

  modport regs (output lcr, divisor, ier, thr_data, thr_wr, rhr_rd, lsr_rd,
                input  rx_data, data_ready, overrun, par_err, frame_err,
                input  thr_empty, tx_empty, isr_id);
  modport rx   (input  lcr, rhr_rd, lsr_rd,
                output rx_data, data_ready, overrun, par_err, frame_err);
  modport tx   (input  lcr, thr_data, thr_wr, output thr_empty, tx_empty);
  modport irq  (input  ier, data_ready, overrun, par_err, frame_err, thr_empty,
                output isr_id);

endinterface

/* hw/uart_register.sv */
module uart_register (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_i,
  input  logic       we_i,
  input  logic [2:0] addr_i,
  input  logic [7:0] wdata_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output logic [7:0] rdata_o,
  output logic       loopback_o,
  uart_reg_if.regs   regs_if
);
  import uart_pkg::*;

  logic [7:0] dll_q;     // Divisor low
  logic [7:0] dlm_q;     // Divisor high
  logic [7:0] scr_q;
  logic [2:0] ier_q;
  lcr_t       lcr_q;
  logic       loop_q;    // MCR bit 4
  logic [7:0] lsr;
  logic [7:0] rd_data;
  logic       wr_en;
  logic       rd_en;
  logic       dlab;

  ////////////////////////////////////////////////////////////
  // Bus handshake and strobes
  ////////////////////////////////////////////////////////////

  assign gnt_o = req_i;  // Always ready, grant in the same cycle
  assign wr_en = req_i & we_i;
  assign rd_en = req_i & ~we_i;
  assign dlab  = lcr_q.strct.dlab;

  // One-cycle strobes, act at the grant edge
  assign regs_if.thr_wr   = wr_en && (addr_i == ADDR_RHR_THR) && !dlab;
  assign regs_if.thr_data = wdata_i;
  assign regs_if.rhr_rd   = rd_en && (addr_i == ADDR_RHR_THR) && !dlab;
  assign regs_if.lsr_rd   = rd_en && (addr_i == ADDR_LSR);

  assign regs_if.lcr     = lcr_q;
  assign regs_if.divisor = {dlm_q, dll_q};
  assign regs_if.ier     = ier_q;
  assign loopback_o      = loop_q;

  // Control registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dll_q   <= '0;  // Zero divisor keeps the baud tick off
      dlm_q   <= '0;
      ier_q   <= '0;
      lcr_q   <= '0;
      loop_q  <= 1'b0;
      scr_q   <= '0;
    end else if (wr_en) begin
      case (addr_i)
        ADDR_RHR_THR: begin
          if (dlab) dll_q <= wdata_i;  // THR itself lives in uart_tx
        end
        ADDR_IER: begin
          if (dlab) begin
            dlm_q <= wdata_i;
          end else begin
            ier_q <= wdata_i[2:0];
          end
        end
        ADDR_LCR: lcr_q.arr <= wdata_i;
        ADDR_MCR: loop_q    <= wdata_i[4];
        ADDR_SCR: scr_q     <= wdata_i;
        default: ;  // ISR and LSR are read only
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Line status, bits 4 and 7 unused
  assign lsr = {1'b0, regs_if.tx_empty, regs_if.thr_empty, 1'b0,
                regs_if.frame_err, regs_if.par_err, regs_if.overrun, regs_if.data_ready};

  always_comb begin
    rd_data = '0;
    case (addr_i)
      ADDR_RHR_THR: rd_data = dlab ? dll_q : regs_if.rx_data;
      ADDR_IER:     rd_data = dlab ? dlm_q : {5'b0, ier_q};
      ADDR_ISR:     rd_data = {4'b0, regs_if.isr_id};
      ADDR_LCR:     rd_data = lcr_q.arr;
      ADDR_MCR:     rd_data = {3'b0, loop_q, 4'b0};
      ADDR_LSR:     rd_data = lsr;
      ADDR_SCR:     rd_data = scr_q;
      default:      rd_data = '0;
    endcase
  end

  // Response one cycle after grant, for reads and writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  // Sampled before the RHR/LSR strobes clear their flags
  always_ff @(posedge clk_i) begin
    if (rd_en) rdata_o <= rd_data;
  end

endmodule

/* hw/uart_rx.sv */
module uart_rx (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   tick_i,
  input  logic   rxd_i,
  uart_reg_if.rx rx_if
);
  import uart_pkg::*;

  logic                          rxd_meta;
  logic                          rxd_s;     // Synchronized serial input
  logic [2:0]                    state;
  logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
  logic [2:0]                    bit_cnt;
  logic [7:0]                    shift;
  logic                          par_acc;   // XOR of data bits so far
  logic                          par_bad;
  logic                          last_bit;
  logic                          mid_start; // Half a bit into the start bit
  logic                          bit_mid;   // Centre of a data, parity or stop bit
  logic                          stop_done;

  assign last_bit  = (bit_cnt == ({1'b0, rx_if.lcr.strct.word_len} + 3'd4));
  assign mid_start = tick_i && (state == ST_START) && (tick_cnt == OVERSAMPLE / 2 - 1);
  assign bit_mid   = tick_i && (tick_cnt == OVERSAMPLE - 1);
  assign stop_done = bit_mid && (state == ST_STOP);

  // Two-flop synchronizer, idles high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd_i;
      rxd_s    <= rxd_meta;
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      par_acc  <= 1'b0;
      par_bad  <= 1'b0;
    end else if (tick_i) begin
      tick_cnt <= tick_cnt + 1'b1;
      case (state)
        ST_IDLE: begin
          tick_cnt <= '0;
          if (!rxd_s) state <= ST_START;  // Falling edge seen
        end
        ST_START: begin
          if (mid_start) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            par_acc  <= 1'b0;
            par_bad  <= 1'b0;
            state    <= rxd_s ? ST_IDLE : ST_DATA;  // High again means glitch
          end
        end
        ST_DATA: begin
          if (bit_mid) begin
            bit_cnt <= bit_cnt + 3'd1;
            par_acc <= par_acc ^ rxd_s;
            if (last_bit) state <= rx_if.lcr.strct.par_en ? ST_PARITY : ST_STOP;
          end
        end
        ST_PARITY: begin
          if (bit_mid) begin
            // Expected bit is par_acc for even, inverted for odd
            par_bad <= rxd_s ^ par_acc ^ ~rx_if.lcr.strct.par_even;
            state   <= ST_STOP;
          end
        end
        ST_STOP: if (bit_mid) state <= ST_IDLE;  // Only the first stop bit is checked
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Data payload, LSB first
  always_ff @(posedge clk_i) begin
    if (mid_start) shift <= '0;  // Unused upper bits read as zero
    else if (bit_mid && (state == ST_DATA)) shift[bit_cnt] <= rxd_s;
    if (stop_done) rx_if.rx_data <= shift;  // Overwritten on overrun
  end

  ////////////////////////////////////////////////////////////
  // Status flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_if.data_ready <= 1'b0;
      rx_if.overrun    <= 1'b0;
      rx_if.par_err    <= 1'b0;
      rx_if.frame_err  <= 1'b0;
    end else begin
      if (rx_if.rhr_rd) rx_if.data_ready <= 1'b0;
      if (rx_if.lsr_rd) begin
        rx_if.overrun   <= 1'b0;
        rx_if.par_err   <= 1'b0;
        rx_if.frame_err <= 1'b0;
      end
      // New byte wins over a clear in the same cycle
      if (stop_done) begin
        rx_if.data_ready <= 1'b1;
        if (rx_if.data_ready && !rx_if.rhr_rd) rx_if.overrun <= 1'b1;
        if (par_bad) rx_if.par_err   <= 1'b1;
        if (!rxd_s)  rx_if.frame_err <= 1'b1;  // Stop bit sampled low
      end
    end
  end

endmodule

/* hw/uart_tx.sv */
module uart_tx (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   tick_i,
  output logic   txd_o,
  uart_reg_if.tx tx_if
);
  import uart_pkg::*;

  logic [7:0]                    thr;       // Holding register
  logic [7:0]                    shift;
  logic [2:0]                    state;
  logic [2:0]                    bit_cnt;   // Data bits, then stop bits
  logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
  logic                          par_acc;
  logic                          bit_end;
  logic                          last_bit;
  logic                          load;

  assign bit_end  = tick_i && (tick_cnt == OVERSAMPLE - 1);
  assign last_bit = (bit_cnt == ({1'b0, tx_if.lcr.strct.word_len} + 3'd4));
  assign load     = tick_i && (state == ST_IDLE) && !tx_if.thr_empty;

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (tx_if.thr_wr) thr <= tx_if.thr_data;
    if (load) shift <= thr;
    else if (bit_end && (state == ST_DATA)) shift <= {1'b0, shift[7:1]};
  end

  ////////////////////////////////////////////////////////////
  // Frame sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state           <= ST_IDLE;
      tick_cnt        <= '0;
      bit_cnt         <= '0;
      par_acc         <= 1'b0;
      txd_o           <= 1'b1;  // Line idles high
      tx_if.thr_empty <= 1'b1;
      tx_if.tx_empty  <= 1'b1;
    end else begin
      if (tick_i) tick_cnt <= tick_cnt + 1'b1;
      case (state)
        ST_IDLE: begin
          tick_cnt <= '0;
          if (load) begin
            state           <= ST_START;
            txd_o           <= 1'b0;
            tx_if.thr_empty <= 1'b1;  // THR free for the next byte
            tx_if.tx_empty  <= 1'b0;
          end
        end
        ST_START: begin
          if (bit_end) begin
            state   <= ST_DATA;
            bit_cnt <= '0;
            txd_o   <= shift[0];
            par_acc <= shift[0];
          end
        end
        ST_DATA: begin
          if (bit_end && last_bit) begin
            bit_cnt <= '0;
            state   <= tx_if.lcr.strct.par_en ? ST_PARITY : ST_STOP;
            txd_o   <= tx_if.lcr.strct.par_en ? par_acc ^ ~tx_if.lcr.strct.par_even : 1'b1;
          end else if (bit_end) begin
            bit_cnt <= bit_cnt + 3'd1;
            txd_o   <= shift[1];  // Next bit, shift happens on this edge
            par_acc <= par_acc ^ shift[1];
          end
        end
        ST_PARITY: begin
          if (bit_end) begin
            state <= ST_STOP;
            txd_o <= 1'b1;
          end
        end
        ST_STOP: begin
          if (bit_end && tx_if.lcr.strct.stop2 && (bit_cnt == '0)) begin
            bit_cnt <= 3'd1;  // Second stop bit
          end else if (bit_end) begin
            state <= ST_IDLE;
            if (tx_if.thr_empty) tx_if.tx_empty <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
      if (tx_if.thr_wr) begin  // Write beats a load on the same edge
        tx_if.thr_empty <= 1'b0;
        tx_if.tx_empty  <= 1'b0;
      end
    end
  end

endmodule

/* verif/uart_checker.sv */
module uart_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_i,
  input  logic        gnt_i,
  input  logic        rvalid_i,
  input  logic [7:0]  rdata_i,
  input  logic        txd_i,
  input  logic        irq_i,
  input  logic [15:0] divisor_i,  // As programmed in DLL/DLM
  input  logic        rd_chk_i,   // Compare the next read response
  input  logic [2:0]  rd_addr_i,
  input  logic [7:0]  rd_exp_i,
  input  logic        irq_chk_i,
  input  logic        irq_exp_i,
  input  logic [7:0]  tx_exp_i,   // Byte the next frame should carry
  input  logic [7:0]  lcr_i,      // Frame format of that byte
  input  logic        loop_i,     // Line must stay idle
  output logic [15:0] frame_cnt_o,
  output logic [15:0] err_cnt_o
);
  import uart_pkg::*;

  int          bit_clks;          // Clocks per serial bit
  logic        req_q;             // Request of the previous cycle
  logic [15:0] frames   = '0;
  logic [15:0] mon_errs = '0;     // Bus, irq_o and loopback line
  logic [15:0] tx_errs  = '0;     // Decoded frames

  assign bit_clks    = (divisor_i + 1) * OVERSAMPLE;
  assign frame_cnt_o = frames;
  assign err_cnt_o   = mon_errs + tx_errs;

  ////////////////////////////////////////////////////////////
  // Bus handshake, responses and irq_o
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) req_q <= req_i;

  always @(negedge clk_i) begin
    if (!reset_i && gnt_i !== req_i) begin  // Granted in the same cycle
      $display("ERR gnt_o: expected 0x%h, got 0x%h", req_i, gnt_i);
      mon_errs++;
    end
    if (!reset_i && rvalid_i !== req_q) begin  // One cycle after the grant
      $display("ERR rvalid_o: expected 0x%h, got 0x%h", req_q, rvalid_i);
      mon_errs++;
    end
    if (!reset_i && rvalid_i && rd_chk_i && rdata_i !== rd_exp_i) begin
      $display("ERR rdata_o (addr 0x%h): expected 0x%h, got 0x%h", rd_addr_i, rd_exp_i, rdata_i);
      mon_errs++;
    end
    if (irq_chk_i && irq_i !== irq_exp_i) begin
      $display("ERR irq_o: expected 0x%h, got 0x%h", irq_exp_i, irq_i);
      mon_errs++;
    end
    if (loop_i && txd_i !== 1'b1) begin  // Pin held high in loopback
      $display("ERR txd_o in loopback: expected 0x1, got 0x%h", txd_i);
      mon_errs++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Serial frames on txd_o
  ////////////////////////////////////////////////////////////

  // Samples each bit in its middle
  task automatic decode_frame();
    logic [7:0] data;
    logic [7:0] exp_data;
    logic       par;
    int         nbits;
    data     = '0;
    nbits    = lcr_i[1:0] + 5;
    exp_data = tx_exp_i & (8'hFF >> (8 - nbits));
    par      = lcr_i[4] ? ^exp_data : ~^exp_data;  // Even or odd
    repeat (bit_clks / 2) @(negedge clk_i);
    if (txd_i !== 1'b0) begin
      $display("Start bit on txd_o ended before the middle of the bit");
      tx_errs++;
    end else begin
      for (int i = 0; i < nbits; i++) begin
        repeat (bit_clks) @(negedge clk_i);
        data[i] = txd_i;  // LSB first
      end
      if (data !== exp_data) begin
        $display("ERR txd_o data: expected 0x%h, got 0x%h", exp_data, data);
        tx_errs++;
      end
      if (lcr_i[3]) begin
        repeat (bit_clks) @(negedge clk_i);
        if (txd_i !== par) begin
          $display("ERR txd_o parity: expected 0x%h, got 0x%h", par, txd_i);
          tx_errs++;
        end
      end
      for (int s = 0; s <= lcr_i[2]; s++) begin
        repeat (bit_clks) @(negedge clk_i);
        if (txd_i !== 1'b1) begin
          $display("ERR txd_o stop bit %0d: expected 0x1, got 0x%h", s, txd_i);
          tx_errs++;
        end
      end
      repeat (bit_clks / 2) @(negedge clk_i);  // End of the last stop bit
      frames++;
    end
  endtask

  always begin
    @(negedge clk_i);
    if (!reset_i && !loop_i && txd_i === 1'b0) decode_frame();
  end

endmodule

/* verif/uart_tb.sv */
module uart_tb;
  import uart_pkg::*;

  localparam logic [15:0] DIV      = 16'd1;
  localparam int          BIT_CLKS = (DIV + 1) * OVERSAMPLE;
  localparam int          TIMEOUT  = 40 * BIT_CLKS;  // Clocks per wait
  localparam int          N_ROWS   = 8;
  localparam int          W_FRAME  = 0;
  localparam int          W_RX     = 1;
  localparam int          W_TX     = 2;
  localparam int          W_RVALID = 3;

  typedef struct packed {
    logic [7:0] lcr;
    logic       loop;   // MCR loopback
    logic       rnd;    // Payload from $random
    logic [7:0] data;
    logic [1:0] fault;  // 0 none, 1 parity, 2 stop, 3 overrun
    logic [7:0] lsr;    // LSR once the frame is in
  } row_t;

  logic        clk;
  logic        reset;
  logic        req;
  logic        we;
  logic [2:0]  addr;
  logic [7:0]  wdata;
  logic        gnt;
  logic        rvalid;
  logic [7:0]  rdata;
  logic        rxd;
  logic        txd;
  logic        irq;
  logic        rd_chk;
  logic [7:0]  rd_exp;
  logic        irq_chk;
  logic        irq_exp;
  logic [7:0]  tx_exp;
  logic [7:0]  lcr_mon;
  logic        loop_mon;
  logic [15:0] frame_cnt;
  logic [15:0] err_cnt;
  logic [15:0] frames;     // Frame count before a THR write
  logic [31:0] rnd_word;
  logic [7:0]  data;
  logic [7:0]  mask;
  int          timeouts;
  int          seed;
  row_t        rows [N_ROWS];
  row_t        r;

  uart i_dut (
    .clk_i    (clk),
    .reset_i  (reset),
    .req_i    (req),
    .we_i     (we),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (rdata),
    .rxd_i    (rxd),
    .txd_o    (txd),
    .irq_o    (irq)
  );

  uart_checker i_checker (
    .clk_i       (clk),
    .reset_i     (reset),
    .req_i       (req),
    .gnt_i       (gnt),
    .rvalid_i    (rvalid),
    .rdata_i     (rdata),
    .txd_i       (txd),
    .irq_i       (irq),
    .divisor_i   (DIV),
    .rd_chk_i    (rd_chk),
    .rd_addr_i   (addr),
    .rd_exp_i    (rd_exp),
    .irq_chk_i   (irq_chk),
    .irq_exp_i   (irq_exp),
    .tx_exp_i    (tx_exp),
    .lcr_i       (lcr_mon),
    .loop_i      (loop_mon),
    .frame_cnt_o (frame_cnt),
    .err_cnt_o   (err_cnt)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    #2;
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // Polls at falling edges until the condition holds
  task automatic wait_for(input int kind, input string what);
    int   n;
    logic hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      case (kind)
        W_FRAME: hit = (frame_cnt != frames);
        W_RX:    hit = (i_dut.reg_if.data_ready === 1'b1);
        W_TX:    hit = (i_dut.reg_if.tx_empty === 1'b1);
        default: hit = (rvalid === 1'b1);
      endcase
    end
    if (!hit) begin
      $display("Timeout: no %s within %0d clocks", what, TIMEOUT);
      timeouts++;
    end
  endtask

  // One request, granted at once, then the rvalid response
  task automatic bus_op(input logic wr, input logic [2:0] a, input logic [7:0] d,
                        input logic chk);
    @(posedge clk);
    #2;
    req    = 1'b1;
    we     = wr;
    addr   = a;
    wdata  = d;
    rd_exp = d;
    rd_chk = chk;
    @(posedge clk);
    #2;
    req = 1'b0;
    wait_for(W_RVALID, "rvalid_o");
  endtask

  task automatic bus_write(input logic [2:0] a, input logic [7:0] d);
    bus_op(1'b1, a, d, 1'b0);
  endtask

  task automatic bus_read(input logic [2:0] a, input logic [7:0] exp_data);
    bus_op(1'b0, a, exp_data, 1'b1);
  endtask

  task automatic check_irq(input logic exp_level);
    @(posedge clk);
    #2;
    irq_exp = exp_level;
    irq_chk = 1'b1;
    @(posedge clk);
    #2;
    irq_chk = 1'b0;
  endtask

  // Serial frame on rxd_i where a bad stop bit stays low for 3/4 of the bit
  task automatic send_frame(input logic [7:0] d, input logic [7:0] lcr, input logic bad_par,
                            input logic bad_stop);
    logic       bits [$];
    logic [7:0] m;
    m = 8'hFF >> (3 - lcr[1:0]);
    bits.push_back(1'b0);
    for (int i = 0; i < lcr[1:0] + 5; i++) bits.push_back(d[i]);
    if (lcr[3]) bits.push_back((lcr[4] ? ^(d & m) : ~^(d & m)) ^ bad_par);
    @(posedge clk);
    #2;
    foreach (bits[i]) begin
      rxd = bits[i];
      repeat (BIT_CLKS) @(posedge clk);
      #2;
    end
    rxd = !bad_stop;
    repeat (BIT_CLKS * 3 / 4) @(posedge clk);
    #2;
    rxd = 1'b1;
    repeat (BIT_CLKS * (lcr[2] ? 9 : 5) / 4) @(posedge clk);  // Rest of stop plus one idle bit
  endtask

  task automatic load_rows();
    //        LCR    loop  rnd   data   fault LSR
    rows[0] = {8'h03, 1'b0, 1'b0, 8'hA5, 2'd0, 8'h61};  // 8N1
    rows[1] = {8'h1A, 1'b0, 1'b0, 8'h3C, 2'd0, 8'h61};  // 7E1
    rows[2] = {8'h0C, 1'b0, 1'b1, 8'h00, 2'd0, 8'h61};  // 5O2
    rows[3] = {8'h1B, 1'b0, 1'b0, 8'h5A, 2'd1, 8'h65};  // 8E1 with bad parity
    rows[4] = {8'h03, 1'b0, 1'b0, 8'h0F, 2'd2, 8'h69};  // 8N1 with low stop bit
    rows[5] = {8'h01, 1'b0, 1'b1, 8'h00, 2'd3, 8'h63};  // 6N1 overrun
    rows[6] = {8'h0B, 1'b1, 1'b0, 8'hC3, 2'd0, 8'h61};  // 8O1 loopback
    rows[7] = {8'h07, 1'b1, 1'b1, 8'h00, 2'd0, 8'h61};  // 8N2 loopback
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed     = 1243;
    timeouts = 0;
    reset    = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    rxd      = 1'b1;  // Idle line
    rd_chk   = 1'b0;
    rd_exp   = '0;
    irq_chk  = 1'b0;
    irq_exp  = 1'b0;
    tx_exp   = '0;
    lcr_mon  = '0;
    loop_mon = 1'b0;
    frames   = '0;
    load_rows();
    apply_reset();

    // Reset values, scratch and divisor latches
    bus_read(ADDR_ISR, 8'h01);
    bus_read(ADDR_LSR, 8'h60);
    check_irq(1'b0);
    bus_write(ADDR_SCR, 8'hA5);
    bus_read(ADDR_SCR, 8'hA5);
    bus_write(ADDR_LCR, 8'h80);
    bus_write(ADDR_RHR_THR, 8'h5A);
    bus_write(ADDR_IER, 8'hC3);
    bus_read(ADDR_RHR_THR, 8'h5A);
    bus_read(ADDR_IER, 8'hC3);
    apply_reset();  // Baud counter back to zero
    bus_write(ADDR_LCR, 8'h80);
    bus_write(ADDR_RHR_THR, DIV[7:0]);
    bus_write(ADDR_IER, DIV[15:8]);

    for (int i = 0; i < N_ROWS; i++) begin
      r        = rows[i];
      rnd_word = $random(seed);
      data     = r.rnd ? rnd_word[7:0] : r.data;
      mask     = 8'hFF >> (3 - r.lcr[1:0]);
      loop_mon = 1'b0;
      lcr_mon  = r.lcr;
      tx_exp   = data;
      bus_write(ADDR_LCR, r.lcr);  // Also drops DLAB
      bus_write(ADDR_MCR, {3'b000, r.loop, 4'h0});
      loop_mon = r.loop;
      frames   = frame_cnt;
      bus_write(ADDR_RHR_THR, data);
      if (r.loop) begin
        wait_for(W_RX, "data_ready in loopback");
      end else begin
        wait_for(W_FRAME, "frame on txd_o");
        bus_read(ADDR_LSR, 8'h60);
        send_frame(data, r.lcr, r.fault == 2'd1, r.fault == 2'd2);
        if (r.fault == 2'd3) send_frame(data, r.lcr, 1'b0, 1'b0);  // RHR still full
        wait_for(W_RX, "data_ready");
      end
      wait_for(W_TX, "tx_empty");
      bus_read(ADDR_LSR, r.lsr);  // Clears the error bits
      bus_read(ADDR_RHR_THR, data & mask);
      bus_read(ADDR_LSR, 8'h60);
    end

    // Interrupt priority
    loop_mon = 1'b0;
    bus_write(ADDR_MCR, 8'h00);
    bus_write(ADDR_LCR, 8'h1B);
    bus_write(ADDR_IER, 8'h05);  // THR empty masked
    bus_read(ADDR_ISR, 8'h01);
    check_irq(1'b0);
    send_frame(8'h96, 8'h1B, 1'b1, 1'b0);
    wait_for(W_RX, "data_ready");
    bus_write(ADDR_IER, 8'h07);  // All three causes pending
    bus_read(ADDR_ISR, 8'h06);
    check_irq(1'b1);
    bus_read(ADDR_LSR, 8'h65);
    bus_read(ADDR_ISR, 8'h04);  // RX data ranks above THR empty
    check_irq(1'b1);
    bus_write(ADDR_IER, 8'h05);
    bus_read(ADDR_RHR_THR, 8'h96);
    bus_read(ADDR_ISR, 8'h01);
    check_irq(1'b0);
    bus_write(ADDR_IER, 8'h07);
    bus_read(ADDR_ISR, 8'h02);
    check_irq(1'b1);
    bus_write(ADDR_IER, 8'h00);
    check_irq(1'b0);

    $display("Checker errors: %0d, timeouts: %0d", err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
